// File: game_pkg.sv
package game_pkg;

	// Bus widths
	typedef logic [12:0] bus_addr_t;           // Word address
	typedef logic [31:0] bus_data_t;           // Bus word

	// Screen and pixel types
	typedef logic [9:0]  coord_t;              // Pixel or line coordinate
	typedef logic [23:0] color_t;              // {red, green, blue}

	// Controller pin counts
	localparam int GPIO_IN_W  = 8;             // Controller inputs
	localparam int GPIO_OUT_W = 3;             // Output pins

	// Address map, word addresses
	localparam bus_addr_t ADDR_P1_POS   = 13'h1000; // x in 9..0, y in 25..16
	localparam bus_addr_t ADDR_P2_POS   = 13'h1001; // Same layout as p1
	localparam bus_addr_t ADDR_P1_COLOR = 13'h1002; // Color in 23..0
	localparam bus_addr_t ADDR_P2_COLOR = 13'h1003; // Same layout as p1
	localparam bus_addr_t ADDR_GPIO_IN  = 13'h1004; // Read only
	localparam bus_addr_t ADDR_GPIO_OUT = 13'h1005; // Pins in 2..0

	// Position word field positions
	localparam int POS_X_LSB = 0;              // x field
	localparam int POS_Y_LSB = 16;             // y field

	// Board background, dark blue
	localparam color_t BG_COLOR = 24'h102040;

endpackage

// File: game_ifs.sv
`timescale 1ns/1ns

// Player state from the register block to the renderer
interface player_if import game_pkg::*; ();

	coord_t p1_x;                              // Player 1 box corner
	coord_t p1_y;
	coord_t p2_x;                              // Player 2 box corner
	coord_t p2_y;
	color_t p1_color;                          // Box fills
	color_t p2_color;

	modport src (
		output p1_x, p1_y, p2_x, p2_y,
		output p1_color, p2_color
	);

	modport dst (
		input p1_x, p1_y, p2_x, p2_y,
		input p1_color, p2_color
	);

endinterface

// Raster scan position and sync from the timing generator
interface scan_if import game_pkg::*; ();

	logic   hs;                                // Active low
	logic   vs;                                // Active low
	logic   active;                            // Visible area
	coord_t x;                                 // Valid while active
	coord_t y;

	modport gen (
		output hs, vs, active, x, y
	);

	// Read side, "use" is a reserved word
	modport user (
		input hs, vs, active, x, y
	);

endinterface

// File: mmio.sv
`timescale 1ns/1ns

module mmio import game_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  bus_addr_t             address,     // Word address from bus master
	input  bus_data_t             data_in,     // Write data
	input  logic                  wren,        // Write strobe
	input  logic [GPIO_IN_W-1:0]  gpio,        // Controller, asynchronous
	output bus_data_t             data_out,    // Read word, one cycle late
	output logic [GPIO_OUT_W-1:0] gpio_output, // Output pins
	player_if.src                 players
);

	coord_t p1_x, p1_y;                        // Player 1 position
	coord_t p2_x, p2_y;                        // Player 2 position
	color_t p1_color, p2_color;

	logic [GPIO_IN_W-1:0] gpio_s1;             // First sync stage
	logic [GPIO_IN_W-1:0] gpio_s2;             // Safe to read

	bus_data_t rd_word;                        // Mapped word for current address

	// Register writes
	always_ff @(posedge clock) begin
		if (reset) begin
			p1_x        <= '0;
			p1_y        <= '0;
			p2_x        <= '0;
			p2_y        <= '0;
			p1_color    <= '0;
			p2_color    <= '0;
			gpio_output <= '0;
		end else if (wren) begin
			case (address)
				ADDR_P1_POS: begin
					p1_x <= data_in[POS_X_LSB +: 10];
					p1_y <= data_in[POS_Y_LSB +: 10];
				end
				ADDR_P2_POS: begin
					p2_x <= data_in[POS_X_LSB +: 10];
					p2_y <= data_in[POS_Y_LSB +: 10];
				end
				ADDR_P1_COLOR: p1_color    <= data_in[23:0];
				ADDR_P2_COLOR: p2_color    <= data_in[23:0];
				ADDR_GPIO_OUT: gpio_output <= data_in[GPIO_OUT_W-1:0];
				default: ;                         // gpio in and unmapped ignored
			endcase
		end
	end

	// Two flop synchronizer on controller pins
	always_ff @(posedge clock) begin
		if (reset) begin
			gpio_s1 <= '0;
			gpio_s2 <= '0;
		end else begin
			gpio_s1 <= gpio;
			gpio_s2 <= gpio_s1;
		end
	end

	// Read map
	always_comb begin
		rd_word = '0;                          // Unmapped reads zero
		case (address)
			ADDR_P1_POS: begin
				rd_word[POS_X_LSB +: 10] = p1_x;
				rd_word[POS_Y_LSB +: 10] = p1_y;
			end
			ADDR_P2_POS: begin
				rd_word[POS_X_LSB +: 10] = p2_x;
				rd_word[POS_Y_LSB +: 10] = p2_y;
			end
			ADDR_P1_COLOR: rd_word[23:0]           = p1_color;
			ADDR_P2_COLOR: rd_word[23:0]           = p2_color;
			ADDR_GPIO_IN:  rd_word[GPIO_IN_W-1:0]  = gpio_s2;
			ADDR_GPIO_OUT: rd_word[GPIO_OUT_W-1:0] = gpio_output;
			default: ;
		endcase
	end

	// Registered read, sees pre-write value on same cycle
	always_ff @(posedge clock) begin
		if (reset)
			data_out <= '0;
		else
			data_out <= rd_word;
	end

	assign players.p1_x     = p1_x;
	assign players.p1_y     = p1_y;
	assign players.p2_x     = p2_x;
	assign players.p2_y     = p2_y;
	assign players.p1_color = p1_color;
	assign players.p2_color = p2_color;

endmodule

// File: vga_timing.sv
`timescale 1ns/1ns

module vga_timing import game_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic clock,
	input  logic reset,
	scan_if.gen  scan
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // Clocks per line
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // Lines per frame
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	typedef enum logic [1:0] {ACTIVE, FRONT, SYNC, BACK} phase_e;

	logic [HW-1:0] h_cnt, h_cnt_n;             // Pixel within line
	logic [VW-1:0] v_cnt, v_cnt_n;             // Line within frame
	logic          line_end, frame_end;
	phase_e        h_phase_n, v_phase_n;       // Phases of next position

	// Phase of a count, phases in line order
	function automatic phase_e phase_of(input int cnt, input int act, input int fp,
		input int sw);
		if (cnt < act)
			return ACTIVE;
		else if (cnt < act + fp)
			return FRONT;
		else if (cnt < act + fp + sw)
			return SYNC;
		else
			return BACK;
	endfunction

	always_comb begin
		line_end  = (h_cnt == HW'(H_TOTAL - 1));
		frame_end = (v_cnt == VW'(V_TOTAL - 1));
		h_cnt_n   = line_end ? '0 : h_cnt + 1'b1;
		if (line_end)
			v_cnt_n = frame_end ? '0 : v_cnt + 1'b1; // Wrap to first line
		else
			v_cnt_n = v_cnt;
		h_phase_n = phase_of(int'(h_cnt_n), H_ACTIVE, H_FRONT, H_SYNC);
		v_phase_n = phase_of(int'(v_cnt_n), V_ACTIVE, V_FRONT, V_SYNC);
	end

	// Outputs decoded from next counts so they line up with counters
	always_ff @(posedge clock) begin
		if (reset) begin
			h_cnt       <= '0;
			v_cnt       <= '0;
			scan.hs     <= 1'b1;               // Position 0,0 is visible
			scan.vs     <= 1'b1;
			scan.active <= 1'b1;
			scan.x      <= '0;
			scan.y      <= '0;
		end else begin
			h_cnt       <= h_cnt_n;
			v_cnt       <= v_cnt_n;
			scan.hs     <= (h_phase_n != SYNC);
			scan.vs     <= (v_phase_n != SYNC);
			scan.active <= (h_phase_n == ACTIVE) && (v_phase_n == ACTIVE);
			scan.x      <= coord_t'(h_cnt_n);
			scan.y      <= coord_t'(v_cnt_n);
		end
	end

endmodule

// File: sprite_renderer.sv
`timescale 1ns/1ns

module sprite_renderer import game_pkg::*; #(
	parameter int PLAYER_SIZE = 16
) (
	input  logic       clock,
	input  logic       reset,
	scan_if.user       scan,
	player_if.dst      players,
	output logic       vga_hs,
	output logic       vga_vs,
	output logic       vga_blank,          // Active low
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	logic   in_p1, in_p2;                      // Pixel inside a box
	color_t pix;                               // Color for this scan position

	// Half open box test, 11 bits so pos + size cannot wrap
	function automatic logic in_box(input coord_t px, input coord_t py,
		input coord_t bx, input coord_t by);
		logic hit_x, hit_y;
		hit_x = (px >= bx) && (11'(px) < 11'(bx) + 11'(PLAYER_SIZE));
		hit_y = (py >= by) && (11'(py) < 11'(by) + 11'(PLAYER_SIZE));
		return hit_x && hit_y;
	endfunction

	always_comb begin
		in_p1 = in_box(scan.x, scan.y, players.p1_x, players.p1_y);
		in_p2 = in_box(scan.x, scan.y, players.p2_x, players.p2_y);
		if (!scan.active)
			pix = '0;                          // Black in blanking
		else if (in_p1)
			pix = players.p1_color;            // Player 1 on top
		else if (in_p2)
			pix = players.p2_color;
		else
			pix = BG_COLOR;
	end

	// Color and sync registered together, one cycle behind scan
	always_ff @(posedge clock) begin
		if (reset) begin
			vga_hs    <= 1'b1;
			vga_vs    <= 1'b1;
			vga_blank <= 1'b0;
			vga_r     <= '0;
			vga_g     <= '0;
			vga_b     <= '0;
		end else begin
			vga_hs    <= scan.hs;
			vga_vs    <= scan.vs;
			vga_blank <= scan.active;
			vga_r     <= pix[23:16];
			vga_g     <= pix[15:8];
			vga_b     <= pix[7:0];
		end
	end

endmodule

// File: skeleton.sv
`timescale 1ns/1ns

module skeleton import game_pkg::*; #(
	parameter int H_ACTIVE    = 640,
	parameter int H_FRONT     = 16,
	parameter int H_SYNC      = 96,
	parameter int H_BACK      = 48,
	parameter int V_ACTIVE    = 480,
	parameter int V_FRONT     = 10,
	parameter int V_SYNC      = 2,
	parameter int V_BACK      = 33,
	parameter int PLAYER_SIZE = 16
) (
	input  logic                  clock,
	input  logic                  reset,
	input  bus_addr_t             address,     // Data memory bus
	input  bus_data_t             data_in,
	input  logic                  wren,
	output bus_data_t             data_out,
	input  logic [GPIO_IN_W-1:0]  gpio,        // Controller inputs
	output logic [GPIO_OUT_W-1:0] gpio_output,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  vga_blank,   // Active low
	output logic [7:0]            vga_r,
	output logic [7:0]            vga_g,
	output logic [7:0]            vga_b
);

	player_if players ();                      // Register block to renderer
	scan_if   scan ();                         // Timing to renderer

	mmio mmio_i (
		.clock       (clock),
		.reset       (reset),
		.address     (address),
		.data_in     (data_in),
		.wren        (wren),
		.gpio        (gpio),
		.data_out    (data_out),
		.gpio_output (gpio_output),
		.players     (players.src)
	);

	vga_timing #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
	) vga_timing_i (
		.clock (clock),
		.reset (reset),
		.scan  (scan.gen)
	);

	sprite_renderer #(
		.PLAYER_SIZE (PLAYER_SIZE)
	) sprite_renderer_i (
		.clock     (clock),
		.reset     (reset),
		.scan      (scan.user),
		.players   (players.dst),
		.vga_hs    (vga_hs),
		.vga_vs    (vga_vs),
		.vga_blank (vga_blank),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b)
	);

endmodule

// File: skeleton_assert.sv
`timescale 1ns/1ns

module renderer_checks #(
	parameter int H_SYNC = 96
) (
	input logic       clock,
	input logic       reset,
	input logic       vga_hs,
	input logic       vga_vs,
	input logic       vga_blank,               // Active low
	input logic [7:0] vga_r,
	input logic [7:0] vga_g,
	input logic [7:0] vga_b
);

	blank_black: assert property (@(posedge clock) disable iff (reset)
		!vga_blank |-> (vga_r == 8'd0 && vga_g == 8'd0 && vga_b == 8'd0))
		else $error("RGB not black while blanked");

	reset_idle: assert property (@(posedge clock)
		reset |=> (vga_hs && vga_vs && !vga_blank))
		else $error("Video outputs not idle after reset");

	// Pulse ends exactly H_SYNC clocks after it starts
	hs_rise_after_fall: assert property (@(posedge clock) disable iff (reset)
		$fell(vga_hs) |-> ##H_SYNC $rose(vga_hs))
		else $error("vga_hs pulse too long or short");

endmodule

// Sync width of the small raster
bind sprite_renderer renderer_checks #(.H_SYNC(3)) renderer_checks_i (.*);

// File: skeleton_tb.sv
`timescale 1ns/1ns

module skeleton_tb import game_pkg::*; ();

	localparam int H_ACTIVE = 16;              // Small raster keeps frames short
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 3;
	localparam int H_BACK = 2;
	localparam int V_ACTIVE = 12;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 1;
	localparam int PLAYER_SIZE = 4;
	localparam int LINE_CYC = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;       // 23 clocks
	localparam int FRAME_CYC = LINE_CYC * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
	localparam int WAIT_MAX = 2 * FRAME_CYC;   // Longest any wait may take
	localparam int P1_X = 2;                   // Player boxes overlap a little
	localparam int P1_Y = 2;
	localparam int P2_X = 4;
	localparam int P2_Y = 3;
	localparam bus_data_t POS_MASK = 32'h03FF_03FF;  // x in 9..0, y in 25..16
	localparam bus_data_t COLOR_MASK = 32'h00FF_FFFF;
	localparam bus_data_t GPIO_OUT_MASK = 32'h0000_0007;
	localparam bus_addr_t IGNORED[3] = '{13'h0123, 13'h1006, ADDR_GPIO_IN};

	typedef struct {
		logic      wr;                         // Write when high, else read
		bus_addr_t addr;
		bus_data_t data;
		bus_data_t exp;                        // Expected read word
	} bus_op_t;

	logic       clock = 1'b0;
	logic       reset = 1'b1;
	bus_addr_t  address = '0;
	bus_data_t  data_in = '0;
	logic       wren = 1'b0;
	bus_data_t  data_out;
	logic [7:0] gpio = '0;
	logic [2:0] gpio_output;
	logic       vga_hs, vga_vs, vga_blank;
	logic [7:0] vga_r, vga_g, vga_b;

	bus_op_t     ops[$];                       // Pending bus table
	logic [15:0] lfsr = 16'd31534;
	string       sig_names[3] = '{"vga_hs", "vga_vs", "vga_blank"};
	int          errors = 0;
	int          err_mark = 0;
	int          tests_ok = 0;
	int          tests_bad = 0;

	skeleton #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
		.PLAYER_SIZE (PLAYER_SIZE)
	) skeleton_i (.*);

	always #20 clock = ~clock;                 // 40 ns period

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output bus_data_t val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};        // One step per bit
		end
	endtask

	task automatic check(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic open_test();
		err_mark = errors;
	endtask

	task automatic close_test(input string name);
		if (errors == err_mark) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: FAIL with %0d errors", name, errors - err_mark);
		end
	endtask

	// Drive one bus cycle and return once the read word is out
	task automatic bus_cycle(input logic wr, input bus_addr_t a, input bus_data_t d);
		@(posedge clock);
		#2;
		wren = wr;
		address = a;
		data_in = d;
		@(posedge clock);
		#1;                                    // data_out settled after edge
	endtask

	task automatic add_op(input logic wr, input bus_addr_t a, input bus_data_t d,
		input bus_data_t exp);
		ops.push_back(bus_op_t'{wr, a, d, exp});
	endtask

	task automatic run_ops();
		foreach (ops[i]) begin
			bus_cycle(ops[i].wr, ops[i].addr, ops[i].data);
			if (!ops[i].wr)
				check($sformatf("data_out @%h", ops[i].addr), data_out, ops[i].exp);
		end
		ops.delete();
	endtask

	function automatic logic video_bit(input int sel);
		case (sel)
			0: return vga_hs;
			1: return vga_vs;
			default: return vga_blank;
		endcase
	endfunction

	// Counts clocks until the chosen output changes to level
	task automatic wait_for(input int sel, input logic level, output int cycles);
		logic prev;
		logic now;
		prev = video_bit(sel);
		for (cycles = 1; cycles <= WAIT_MAX; cycles++) begin
			@(posedge clock);
			#1;
			now = video_bit(sel);
			if (now == level && prev != level)
				return;
			prev = now;
		end
		errors++;
		$display("Timed out after %0d cycles waiting for %s to change to %0d", WAIT_MAX,
			sig_names[sel], level);
		cycles = -1;
	endtask

	function automatic logic in_box(input int x, input int y, input int bx, input int by);
		return x >= bx && x < bx + PLAYER_SIZE && y >= by && y < by + PLAYER_SIZE;
	endfunction

	// Player 1 drawn over player 2 and both over the board
	function automatic color_t expect_pixel(input int x, input int y, input color_t c1,
		input color_t c2);
		if (in_box(x, y, P1_X, P1_Y))
			return c1;
		else if (in_box(x, y, P2_X, P2_Y))
			return c2;
		return BG_COLOR;
	endfunction

	initial begin
		bus_data_t w[4];
		bus_data_t v;
		int n;
		int period;
		int px;
		int py;
		color_t c1;
		color_t c2;
		repeat (4) @(posedge clock);
		#2 reset = 1'b0;

		open_test();
		for (int i = 0; i < 4; i++)
			add_op(1'b0, ADDR_P1_POS + bus_addr_t'(i), 0, 0);
		add_op(1'b0, ADDR_GPIO_OUT, 0, 0);
		run_ops();
		check("gpio_output", bus_data_t'(gpio_output), 0);
		close_test("reset state");

		open_test();
		for (int i = 0; i < 4; i++) begin
			rand_bits(32, w[i]);
			add_op(1'b1, ADDR_P1_POS + bus_addr_t'(i), w[i], 0);
		end
		for (int i = 0; i < 4; i++)
			add_op(1'b0, ADDR_P1_POS + bus_addr_t'(i), 0, w[i] & (i < 2 ? POS_MASK : COLOR_MASK));
		for (int i = 0; i < 3; i++) begin
			rand_bits(32, v);
			add_op(1'b1, IGNORED[i], v, 0);    // Must not land anywhere
		end
		for (int i = 0; i < 4; i++)
			add_op(1'b0, ADDR_P1_POS + bus_addr_t'(i), 0, w[i] & (i < 2 ? POS_MASK : COLOR_MASK));
		add_op(1'b0, ADDR_GPIO_OUT, 0, 0);     // Output pins untouched too
		for (int i = 0; i < 3; i++)
			add_op(1'b0, IGNORED[i], 0, 0);    // gpio pins still low
		run_ops();
		close_test("register readback");

		open_test();
		rand_bits(8, v);
		for (int i = 0; i < 2; i++) begin
			@(posedge clock);
			#2 gpio = v[7:0];
			@(posedge clock);                  // Read address goes out after the next edge
			add_op(1'b0, ADDR_GPIO_IN, 0, v & 32'h0000_00FF);
			run_ops();
			v = ~v;                            // Every pin toggles
		end
		rand_bits(32, v);
		for (int i = 0; i < 2; i++) begin
			bus_cycle(1'b1, ADDR_GPIO_OUT, v);
			check("gpio_output", bus_data_t'(gpio_output), v & GPIO_OUT_MASK);
			add_op(1'b0, ADDR_GPIO_OUT, 0, v & GPIO_OUT_MASK);
			run_ops();
			v = ~v;
		end
		close_test("controller io");

		open_test();
		wait_for(0, 1'b0, n);
		wait_for(0, 1'b0, period);
		check("vga_hs period", period, LINE_CYC);
		wait_for(0, 1'b1, n);
		check("vga_hs low width", n, H_SYNC);
		wait_for(1, 1'b0, n);
		wait_for(1, 1'b0, period);
		check("vga_vs period", period, FRAME_CYC);
		n = 0;
		repeat (FRAME_CYC) begin               // Exactly one frame window
			@(posedge clock);
			#1;
			n += int'(vga_blank);
		end
		check("vga_blank high cycles", n, H_ACTIVE * V_ACTIVE);
		close_test("scan timing");

		open_test();
		rand_bits(24, v);
		c1 = v[23:0];
		rand_bits(24, v);
		c2 = (v[23:0] == c1) ? ~c1 : v[23:0];
		bus_cycle(1'b1, ADDR_P1_POS, (bus_data_t'(P1_Y) << 16) | bus_data_t'(P1_X));
		bus_cycle(1'b1, ADDR_P2_POS, (bus_data_t'(P2_Y) << 16) | bus_data_t'(P2_X));
		bus_cycle(1'b1, ADDR_P1_COLOR, bus_data_t'(c1));
		bus_cycle(1'b1, ADDR_P2_COLOR, bus_data_t'(c2));
		wait_for(1, 1'b0, n);                  // Into vertical sync
		wait_for(2, 1'b1, n);                  // First visible pixel of next frame
		px = 0;
		py = 0;
		for (int k = 0; k < WAIT_MAX && py < V_ACTIVE; k++) begin
			if (vga_blank) begin
				check($sformatf("{vga_r,vga_g,vga_b} at (%0d,%0d)", px, py),
					bus_data_t'({vga_r, vga_g, vga_b}),
					bus_data_t'(expect_pixel(px, py, c1, c2)));
				px++;
				if (px == H_ACTIVE) begin
					px = 0;
					py++;
				end
			end
			if (py < V_ACTIVE) begin
				@(posedge clock);
				#1;
			end
		end
		if (py < V_ACTIVE) begin
			errors++;
			$display("Frame ended early, only %0d visible lines seen", py);
		end
		close_test("pixel colors");

		$display("%0d tests ok, %0d tests with errors, %0d errors", tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: build.f
game_pkg.sv
game_ifs.sv
mmio.sv
vga_timing.sv
sprite_renderer.sv
skeleton.sv
skeleton_assert.sv
skeleton_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert --top-module skeleton_tb -f build.f -o skeleton_sim
./obj_dir/skeleton_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "test passed" sim.log
